//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    input  logic [ADDR_SIZE+1:0] pc_id,
    input  word_t                inst_id,
    input  logic                 flush,
    output logic                 stall,
    mem_wb_if.consumer           wb,
    id_ex_if.producer            id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;

    word_t      imm;
    alu_op_t    alu_op;
    logic       alu_src;
    logic       branch;
    logic       branch_ne;
    logic       jal;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    wb_sel_t    wb_sel;

    word_t      regs [1:31];

    assign opcode = inst_id[6:0];
    assign funct3 = inst_id[14:12];
    assign funct7 = inst_id[31:25];
    assign rs1    = inst_id[19:15];
    assign rs2    = inst_id[24:20];
    assign rd     = inst_id[11:7];

    assign imm_i = {{20{inst_id[31]}}, inst_id[31:20]};
    assign imm_s = {{20{inst_id[31]}}, inst_id[31:25], inst_id[11:7]};
    assign imm_b = {{19{inst_id[31]}}, inst_id[31], inst_id[7], inst_id[30:25],
                    inst_id[11:8], 1'b0};
    assign imm_j = {{11{inst_id[31]}}, inst_id[31], inst_id[19:12], inst_id[20],
                    inst_id[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        jal       = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_SUB,  F3_ADD}: alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
                    default:           reg_write = 1'b0; // unsupported, no-op.
                endcase
            end
            OP_IMM: begin
                reg_write = (funct3 == F3_ADD); // addi only.
                alu_src   = 1'b1;
                imm       = imm_i;
            end
            OP_LOAD: begin
                reg_write = (funct3 == F3_LW);
                mem_read  = (funct3 == F3_LW);
                alu_src   = 1'b1;
                imm       = imm_i;
                wb_sel    = WB_LOAD;
            end
            OP_STORE: begin
                mem_write = (funct3 == F3_SW);
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            OP_BRANCH: begin
                branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
                imm       = imm_b;
            end
            OP_JAL: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                imm       = imm_j;
                wb_sel    = WB_LINK;
            end
            default: ;
        endcase
        if (rd == '0) begin
            reg_write = 1'b0; // x0 stays zero.
        end
    end

    // read with same-cycle writeback bypass
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.reg_write && wb.rd == idx) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge CLK) begin
        if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign stall = id_ex.mem_read && (id_ex.rd == rs1 || id_ex.rd == rs2);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex.alu_op    <= ALU_ADD;
            id_ex.alu_src   <= 1'b0;
            id_ex.branch    <= 1'b0;
            id_ex.branch_ne <= 1'b0;
            id_ex.jal       <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.wb_sel    <= WB_ALU;
        end else if (clear || flush || stall) begin
            id_ex.branch    <= 1'b0; // bubble.
            id_ex.jal       <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else begin
            id_ex.alu_op    <= alu_op;
            id_ex.alu_src   <= alu_src;
            id_ex.branch    <= branch;
            id_ex.branch_ne <= branch_ne;
            id_ex.jal       <= jal;
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
            id_ex.reg_write <= reg_write;
            id_ex.wb_sel    <= wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        id_ex.pc      <= pc_id;
        id_ex.rs1_val <= read_reg(rs1);
        id_ex.rs2_val <= read_reg(rs2);
        id_ex.rs1     <= rs1;
        id_ex.rs2     <= rs2;
        id_ex.rd      <= rd;
        id_ex.imm     <= imm;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    id_ex_if.consumer            id_ex,
    mem_wb_if.consumer           wb,
    ex_mem_if.producer           ex_mem,
    output logic                 redirect,
    output logic [ADDR_SIZE+1:0] redirect_pc
);

    word_t                mem_fwd;
    fwd_sel_t             fwd_a;
    fwd_sel_t             fwd_b;
    word_t                op_a;
    word_t                rs2_fwd;
    word_t                op_b;
    word_t                alu_result;
    logic                 taken;
    logic [ADDR_SIZE+1:0] link;

    // MEM has priority, it holds the younger result
    function automatic fwd_sel_t pick_fwd(input reg_idx_t src);
        fwd_sel_t sel;
        if (ex_mem.reg_write && ex_mem.rd == src && src != '0) begin
            sel = FWD_MEM;
        end else if (wb.reg_write && wb.rd == src && src != '0) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val);
        word_t val;
        case (sel)
            FWD_MEM: val = mem_fwd;
            FWD_WB:  val = wb.data;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign mem_fwd = (ex_mem.wb_sel == WB_LINK) ? word_t'(ex_mem.link) : ex_mem.alu_result;

    always_comb begin
        fwd_a   = pick_fwd(id_ex.rs1);
        fwd_b   = pick_fwd(id_ex.rs2);
        op_a    = fwd_value(fwd_a, id_ex.rs1_val);
        rs2_fwd = fwd_value(fwd_b, id_ex.rs2_val);
        op_b    = id_ex.alu_src ? id_ex.imm : rs2_fwd;
    end

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b; // add, load and store address.
        endcase
    end

    assign taken       = id_ex.branch && ((op_a == rs2_fwd) ^ id_ex.branch_ne);
    assign redirect    = taken || id_ex.jal;
    assign redirect_pc = id_ex.pc + id_ex.imm[ADDR_SIZE+1:0];
    assign link        = id_ex.pc + (ADDR_SIZE+2)'(4);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.wb_sel    <= WB_ALU;
        end else if (clear) begin
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.wb_sel    <= id_ex.wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.link       <= link;
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import isa_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [ADDR_SIZE+1:0] redirect_pc,
    output logic [ADDR_SIZE-1:0] iaddr,
    input  word_t                idata,
    output logic [ADDR_SIZE+1:0] pc_id,
    output word_t                inst_id
);

    logic [ADDR_SIZE+1:0] pc;

    assign iaddr = pc[ADDR_SIZE+1:2]; // word address.

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + (ADDR_SIZE+2)'(4);
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc_id   <= '0;
            inst_id <= NOP_INST;
        end else if (clear || redirect) begin
            inst_id <= NOP_INST; // squash younger fetch.
        end else if (!stall) begin
            pc_id   <= pc;
            inst_id <= idata;
        end
    end

endmodule

//--- isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000; // add, sub, addi.
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

endpackage

//--- list.f
isa_pkg.sv
pipe_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
risc_pipeline.sv
tb_clock.sv
tb_top.sv

//--- memory_stage.sv
`timescale 1ns/1ns

module memory_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    ex_mem_if.consumer           ex_mem,
    output logic [ADDR_SIZE-1:0] daddr,
    output word_t                ddata_w,
    input  word_t                ddata_r,
    output logic                 mem_read,
    output logic                 mem_write,
    mem_wb_if.producer           wb
);

    wb_sel_t              wb_sel_q;
    word_t                load_q;
    word_t                alu_q;
    logic [ADDR_SIZE+1:0] link_q;

    assign daddr     = ex_mem.alu_result[ADDR_SIZE+1:2]; // word address.
    assign ddata_w   = ex_mem.store_data;
    assign mem_read  = ex_mem.mem_read;
    assign mem_write = ex_mem.mem_write;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wb.reg_write <= 1'b0;
            wb_sel_q     <= WB_ALU;
        end else if (clear) begin
            wb.reg_write <= 1'b0;
        end else begin
            wb.reg_write <= ex_mem.reg_write;
            wb_sel_q     <= ex_mem.wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        wb.rd  <= ex_mem.rd;
        load_q <= ddata_r;
        alu_q  <= ex_mem.alu_result;
        link_q <= ex_mem.link;
    end

    always_comb begin
        case (wb_sel_q)
            WB_LOAD: wb.data = load_q;
            WB_LINK: wb.data = word_t'(link_q);
            default: wb.data = alu_q;
        endcase
    end

endmodule

//--- pipe_if.sv
`timescale 1ns/1ns

interface id_ex_if import isa_pkg::*, pipe_pkg::*; #(parameter int ADDR_SIZE = 10);
    logic [ADDR_SIZE+1:0] pc;
    word_t                rs1_val;
    word_t                rs2_val;
    reg_idx_t             rs1;
    reg_idx_t             rs2;
    reg_idx_t             rd;
    word_t                imm;
    alu_op_t              alu_op;
    logic                 alu_src;
    logic                 branch;
    logic                 branch_ne;
    logic                 jal;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;
    wb_sel_t              wb_sel;

    modport producer (output pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op, alu_src,
                      branch, branch_ne, jal, mem_read, mem_write, reg_write, wb_sel);
    modport consumer (input pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op, alu_src,
                      branch, branch_ne, jal, mem_read, mem_write, reg_write, wb_sel);
endinterface

interface ex_mem_if import isa_pkg::*, pipe_pkg::*; #(parameter int ADDR_SIZE = 10);
    word_t                alu_result;
    word_t                store_data;
    reg_idx_t             rd;
    logic [ADDR_SIZE+1:0] link;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;
    wb_sel_t              wb_sel;

    modport producer (output alu_result, store_data, rd, link,
                      mem_read, mem_write, reg_write, wb_sel);
    modport consumer (input alu_result, store_data, rd, link,
                      mem_read, mem_write, reg_write, wb_sel);
endinterface

interface mem_wb_if import isa_pkg::*;;
    reg_idx_t rd;
    logic     reg_write;
    word_t    data;

    modport producer (output rd, reg_write, data);
    modport consumer (input rd, reg_write, data);
endinterface

//--- pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG, // value read in decode.
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_sel_t;

endpackage

//--- risc_pipeline.sv
`timescale 1ns/1ns

module risc_pipeline import isa_pkg::*; #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 CLEAR,
    output logic [ADDR_SIZE-1:0] iaddr,
    input  word_t                idata,
    output logic [ADDR_SIZE-1:0] daddr,
    output word_t                ddata_w,
    input  word_t                ddata_r,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 reg_write_enable,
    output reg_idx_t             write_register,
    output word_t                reg_write_data
);

    logic                 stall;
    logic                 redirect;
    logic [ADDR_SIZE+1:0] redirect_pc;
    logic [ADDR_SIZE+1:0] pc_id;
    word_t                inst_id;

    id_ex_if  #(.ADDR_SIZE(ADDR_SIZE)) id_ex_bus ();
    ex_mem_if #(.ADDR_SIZE(ADDR_SIZE)) ex_mem_bus ();
    mem_wb_if                          mem_wb_bus ();

    fetch_stage #(.ADDR_SIZE(ADDR_SIZE)) u_fetch (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .clear       (CLEAR),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .iaddr       (iaddr),
        .idata       (idata),
        .pc_id       (pc_id),
        .inst_id     (inst_id)
    );

    decode_stage #(.ADDR_SIZE(ADDR_SIZE)) u_decode (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .clear   (CLEAR),
        .pc_id   (pc_id),
        .inst_id (inst_id),
        .flush   (redirect),
        .stall   (stall),
        .wb      (mem_wb_bus.consumer),
        .id_ex   (id_ex_bus.producer)
    );

    execute_stage #(.ADDR_SIZE(ADDR_SIZE)) u_execute (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .clear       (CLEAR),
        .id_ex       (id_ex_bus.consumer),
        .wb          (mem_wb_bus.consumer),
        .ex_mem      (ex_mem_bus.producer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage #(.ADDR_SIZE(ADDR_SIZE)) u_memory (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .clear     (CLEAR),
        .ex_mem    (ex_mem_bus.consumer),
        .daddr     (daddr),
        .ddata_w   (ddata_w),
        .ddata_r   (ddata_r),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wb        (mem_wb_bus.producer)
    );

    assign reg_write_enable = mem_wb_bus.reg_write; // observation ports.
    assign write_register   = mem_wb_bus.rd;
    assign reg_write_data   = mem_wb_bus.data;

endmodule

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "^Result: PASSED$" || exit 1
exit 0

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic CLK,
    output logic RESET_N
);

    initial begin
        CLK     = 1'b0;
        RESET_N = 1'b0;
        repeat (5) @(posedge CLK);
        RESET_N <= 1'b1;
    end

    always #20 CLK = ~CLK; // 40 ns period.

endmodule

//--- tb_top.sv
`timescale 1ns/1ns

module tb_top import isa_pkg::*;;

    localparam int PROG_LEN = 200;
    localparam int LAST     = PROG_LEN - 1;
    localparam int PHASE1   = 100;
    localparam int LIMIT    = PHASE1 + 10 + 3 * PROG_LEN + 50 + 20;
    localparam int K_ALU = 0, K_ADDI = 1, K_LW = 2, K_SW = 3, K_BR = 4, K_JAL = 5;

    logic CLK, por_n, soft_rst_n, rst_n, CLEAR;
    logic [9:0]  iaddr, daddr;
    logic [31:0] idata, ddata_w, ddata_r;
    logic        mem_read, mem_write, reg_write_enable;
    logic [4:0]  write_register;
    logic [31:0] reg_write_data;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:1023];
    int kind [0:LAST], f_rd [0:LAST], f_rs1 [0:LAST], f_rs2 [0:LAST], f_imm [0:LAST];
    int sub_op [0:LAST];
    logic [31:0] lfsr = 32'ha39;
    int          exp_rd [$];
    logic [31:0] exp_val [$], exp_addr [$], exp_data [$];
    int errors = 0, n_writes = 0, n_stores = 0, cycles = 0;
    bit checking = 0;

    tb_clock u_clock (.CLK(CLK), .RESET_N(por_n));

    assign rst_n   = por_n & soft_rst_n;
    assign idata   = imem[iaddr]; // combinational instruction memory.
    assign ddata_r = mem_read ? dmem[daddr] : ~dmem[daddr]; // valid only while mem_read is high.

    risc_pipeline #(.ADDR_SIZE(10)) u_risc_pipeline (
        .CLK(CLK), .RESET_N(rst_n), .CLEAR(CLEAR),
        .iaddr(iaddr), .idata(idata), .daddr(daddr), .ddata_w(ddata_w),
        .ddata_r(ddata_r), .mem_read(mem_read), .mem_write(mem_write),
        .reg_write_enable(reg_write_enable), .write_register(write_register),
        .reg_write_data(reg_write_data)
    );

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    function automatic int rand_bits(input int n);
        int val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return 32'(a) * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // random program over registers x0 to x7
    task automatic build_program();
        logic [31:0] im;
        int n;
        logic [6:0] f7;
        logic [2:0] f3;
        for (int i = 0; i < LAST; i++) begin
            kind[i]   = (i < 7) ? K_ADDI : rand_bits(3) % 6;
            f_rd[i]   = (i < 7) ? i + 1 : rand_bits(3);
            f_rs1[i]  = (i < 7) ? 0 : rand_bits(3);
            f_rs2[i]  = rand_bits(3);
            sub_op[i] = rand_bits(3) % 6;
            f_imm[i]  = (rand_bits(12) ^ 2048) - 2048;
            if (kind[i] == K_LW || kind[i] == K_SW) begin
                f_rs1[i] = 0;
                f_imm[i] = rand_bits(6) * 4; // 64-word window.
            end
            if (kind[i] == K_BR || kind[i] == K_JAL) begin
                n = 2 + rand_bits(2);
                if (i + n > LAST) n = LAST - i;
                f_imm[i] = n * 4;
            end
            im = 32'(f_imm[i]);
            case (kind[i])
                K_ALU: begin
                    f7 = (sub_op[i] == 1) ? F7_SUB : F7_BASE;
                    case (sub_op[i])
                        2:       f3 = F3_AND;
                        3:       f3 = F3_OR;
                        4:       f3 = F3_XOR;
                        5:       f3 = F3_SLT;
                        default: f3 = F3_ADD;
                    endcase
                    imem[i] = {f7, 5'(f_rs2[i]), 5'(f_rs1[i]), f3, 5'(f_rd[i]), OP_REG};
                end
                K_ADDI: imem[i] = {im[11:0], 5'(f_rs1[i]), F3_ADD, 5'(f_rd[i]), OP_IMM};
                K_LW:   imem[i] = {im[11:0], 5'd0, F3_LW, 5'(f_rd[i]), OP_LOAD};
                K_SW:   imem[i] = {im[11:5], 5'(f_rs2[i]), 5'd0, F3_SW, im[4:0], OP_STORE};
                K_BR: begin
                    f3 = sub_op[i][0] ? F3_BNE : F3_BEQ;
                    imem[i] = {im[12], im[10:5], 5'(f_rs2[i]), 5'(f_rs1[i]), f3,
                               im[4:1], im[11], OP_BRANCH};
                end
                default: imem[i] = {im[20], im[10:1], im[11], im[19:12], 5'(f_rd[i]), OP_JAL};
            endcase
        end
        imem[LAST] = {20'd0, 5'd0, OP_JAL}; // jump to itself.
        for (int i = PROG_LEN; i < 1024; i++) imem[i] = fill_word(i); // squashed fetches only.
    endtask

    // instruction-set model filling the expected queues
    task automatic run_model();
        logic [31:0] r [0:7];
        logic [31:0] m [0:63];
        logic [31:0] a, b, v;
        int pc = 0;
        exp_rd.delete();
        exp_val.delete();
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < 8; k++) r[k] = '0;
        for (int k = 0; k < 64; k++) m[k] = fill_word(k);
        while (pc != LAST) begin
            a = r[f_rs1[pc]];
            b = r[f_rs2[pc]];
            v = '0;
            case (kind[pc])
                K_ALU: case (sub_op[pc])
                    0: v = a + b;
                    1: v = a - b;
                    2: v = a & b;
                    3: v = a | b;
                    4: v = a ^ b;
                    default: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
                K_ADDI: v = a + 32'(f_imm[pc]);
                K_LW:   v = m[f_imm[pc] / 4];
                K_SW: begin
                    m[f_imm[pc] / 4] = b;
                    exp_addr.push_back(32'(f_imm[pc] / 4));
                    exp_data.push_back(b);
                end
                K_JAL:  v = 32'(pc * 4 + 4);
                default: ;
            endcase
            if (kind[pc] != K_SW && kind[pc] != K_BR && f_rd[pc] != 0) begin
                r[f_rd[pc]] = v;
                exp_rd.push_back(f_rd[pc]);
                exp_val.push_back(v);
            end
            if (kind[pc] == K_JAL || (kind[pc] == K_BR && ((a == b) ^ sub_op[pc][0])))
                pc = pc + f_imm[pc] / 4;
            else
                pc = pc + 1;
        end
    endtask

    task automatic check_idle(input string when);
        if (mem_read || mem_write || reg_write_enable) begin
            errors++;
            $display("memory or register strobe active %s", when);
        end
    endtask

    always @(negedge CLK) begin
        if (checking && rst_n && reg_write_enable) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("register write seen after the last expected write");
            end else begin
                check_value("write_register", 32'(write_register), 32'(exp_rd.pop_front()));
                check_value("reg_write_data", reg_write_data, exp_val.pop_front());
                n_writes++;
            end
        end
        if (checking && rst_n && mem_write) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("store seen after the last expected store");
            end else begin
                check_value("daddr", 32'(daddr), exp_addr.pop_front());
                check_value("ddata_w", ddata_w, exp_data.pop_front());
                n_stores++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the program did not complete", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        CLEAR      = 1'b0;
        soft_rst_n = 1'b1;
        build_program();
        for (int k = 0; k < 1024; k++) dmem[k] = fill_word(k);
        run_model();
        @(negedge CLK);
        check_idle("during reset");
        wait (por_n);
        checking = 1;
        repeat (PHASE1) @(posedge CLK);
        CLEAR <= 1'b1;
        @(posedge CLK);
        CLEAR <= 1'b0;
        checking = 0; // flushed writes break the sequence.
        @(negedge CLK);
        check_idle("after clear");
        @(posedge CLK);
        soft_rst_n <= 1'b0;
        repeat (5) begin
            @(negedge CLK);
            check_idle("during reset");
        end
        for (int k = 0; k < 1024; k++) dmem[k] = fill_word(k);
        run_model();
        @(posedge CLK);
        soft_rst_n <= 1'b1;
        checking = 1;
        while (exp_rd.size() != 0 || exp_addr.size() != 0) @(posedge CLK);
        repeat (20) @(posedge CLK); // catch late extra writes.
        $display("writes %0d, stores %0d, errors %0d", n_writes, n_stores, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
